//--- source/addArchPkg.sv
package addArchPkg;

	// datapath structure, picked once at elaboration
	// ripple gives linear compressors and a plain carry-propagate add
	// the two prefix styles both use tree compressors
	typedef enum logic [1:0] {
		archRipple    = 2'd0,
		archBrentKung = 2'd1,
		archSklansky  = 2'd2
	} adderArch_e;

	// default word width in bits
	localparam int defWidth = 16;

	// default operand count
	// the (m,2) compressor slice needs at least 4 inputs
	localparam int defDepth = 6;

	// fastest variant by default
	localparam adderArch_e defArch = archSklansky;

	// flattened operand bundle width
	localparam int defOpBits = defDepth * defWidth;

	// intermediate carries passed between neighbouring bit slices
	localparam int defLinks = defDepth - 3;

endpackage

//--- source/mopIfPkg.sv
package mopIfPkg;

	import addArchPkg::*;

	// one operand set as it arrives at the unit
	// valid sits on top, operand 0 in the low word
	typedef struct packed {
		logic                              valid;    // plain strobe, no ready
		logic [defDepth-1:0][defWidth-1:0] operands; // index 0 is the lsb word
	} operandSet_t;

	// registered result
	// sum wraps modulo 2**defWidth, no carry-out kept
	typedef struct packed {
		logic                valid; // one per valid input set
		logic [defWidth-1:0] sum;
	} sumResult_t;

	// total bits of each bundle
	localparam int opSetBits  = 1 + defOpBits;
	localparam int resultBits = 1 + defWidth;

endpackage

//--- source/bitCompressor.sv
module bitCompressor
	import addArchPkg::*;
#(
	parameter int         depth = defDepth, // bits of equal weight
	parameter adderArch_e arch  = defArch
) (
	input  logic [depth-1:0] bits,     // one bit per operand
	input  logic [depth-4:0] carryIn,  // from the slice one weight below
	output logic             sum,
	output logic             carry,    // weight +1, ends up in the carry vector
	output logic [depth-4:0] carryOut  // to the slice one weight above
);

	localparam int cells = depth - 2; // full adders per slice

	// full adder cell, returns {carry, sum}
	function automatic logic [1:0] fullAdd(
		input logic x,
		input logic y,
		input logic z
	);
		logic s;
		logic c;
		s = x ^ y ^ z;
		c = (x & y) | (z & (x ^ y)); // majority
		return {c, s};
	endfunction

	logic [cells-1:0] cellCarry; // top entry leaves as carry, rest go up a weight

	if (arch == archRipple) begin : gLinear
		logic [cells-1:0] partSum; // running sum along the chain

		// first cell eats three operand bits
		assign {cellCarry[0], partSum[0]} = fullAdd(bits[0], bits[1], bits[2]);

		// each later cell adds one operand bit and one carry from below
		for (genvar k = 1; k < cells; k++) begin : gCell
			assign {cellCarry[k], partSum[k]} =
				fullAdd(bits[k+2], carryIn[k-1], partSum[k-1]);
		end

		assign sum = partSum[cells-1]; // end of chain
	end else begin : gTree
		// node queue, operand bits first
		// every cell takes the next three nodes and appends its sum
		// followed by one incoming carry, so depth is log-ish
		logic [3*depth-6:0] node;

		assign node[depth-1:0] = bits;

		for (genvar k = 0; k < cells; k++) begin : gCell
			assign {cellCarry[k], node[depth+2*k]} =
				fullAdd(node[3*k], node[3*k+1], node[3*k+2]);
			if (k < cells - 1) begin : gFeed
				assign node[depth+2*k+1] = carryIn[k]; // late arrivals go in last
			end
		end

		assign sum = node[3*depth-6]; // last node left in the queue
	end

	assign carryOut = cellCarry[cells-2:0];
	assign carry    = cellCarry[cells-1];

endmodule

//--- source/carrySaveArray.sv
module carrySaveArray
	import addArchPkg::*;
#(
	parameter int         width = defWidth,
	parameter int         depth = defDepth,
	parameter adderArch_e arch  = defArch
) (
	input  logic [depth*width-1:0] operands, // operand k at bits k*width
	output logic [width-1:0]       sum,
	output logic [width-1:0]       carry     // already weighted, bit 0 is zero
);

	localparam int links = depth - 3; // slice to slice carries

	logic [depth*width-1:0]     byWeight;   // bit i of every operand side by side
	logic [links*(width+1)-1:0] chain;      // slice i reads group i, writes group i+1
	logic [width-1:0]           sliceCarry; // unshifted slice carries

	// regroup by weight
	for (genvar i = 0; i < width; i++) begin : gWeight
		for (genvar k = 0; k < depth; k++) begin : gOp
			assign byWeight[i*depth+k] = operands[k*width+i];
		end
	end

	assign chain[links-1:0] = '0; // nothing below bit 0

	for (genvar i = 0; i < width; i++) begin : gSlice
		bitCompressor #(
			.depth(depth),
			.arch (arch)
		) i_slice (
			.bits    (byWeight[i*depth +: depth]),
			.carryIn (chain[i*links +: links]),
			.sum     (sum[i]),
			.carry   (sliceCarry[i]),
			.carryOut(chain[(i+1)*links +: links])
		);
	end

	// top link group and top slice carry fall off mod 2**width
	assign carry = {sliceCarry[width-2:0], 1'b0};

endmodule

//--- source/prefixCarryNet.sv
module prefixCarryNet
	import addArchPkg::*;
#(
	parameter int         width = defWidth,
	parameter adderArch_e arch  = defArch
) (
	input  logic [width-1:0] genIn,   // per bit generate
	input  logic [width-1:0] propIn,  // per bit propagate
	output logic [width-1:0] genOut,  // group generate over bits 0..i
	output logic [width-1:0] propOut  // group propagate over bits 0..i
);

	localparam int levels = $clog2(width); // tree depth

	// prefix operator, high group absorbs the low group, returns {g, p}
	function automatic logic [1:0] gpDot(
		input logic gHi,
		input logic pHi,
		input logic gLo,
		input logic pLo
	);
		logic g;
		logic p;
		g = gHi | (pHi & gLo);
		p = pHi & pLo;
		return {g, p};
	endfunction

	if (arch == archRipple) begin : gSerial
		// one node per bit, width-1 deep
		assign genOut[0]  = genIn[0];
		assign propOut[0] = propIn[0];
		for (genvar i = 1; i < width; i++) begin : gBit
			assign {genOut[i], propOut[i]} =
				gpDot(genIn[i], propIn[i], genOut[i-1], propOut[i-1]);
		end
	end else if (arch == archBrentKung) begin : gBrentKung
		// up tree on levels 1..levels, down tree after that
		logic [2*levels-1:0][width-1:0] gLvl;
		logic [2*levels-1:0][width-1:0] pLvl;

		assign gLvl[0] = genIn;
		assign pLvl[0] = propIn;

		for (genvar l = 1; l <= levels; l++) begin : gUp
			localparam int span = 2 ** (l - 1); // half of the block
			for (genvar i = 0; i < width; i++) begin : gBit
				if ((i + 1) % (2 * span) == 0) begin : gNode // block top
					assign {gLvl[l][i], pLvl[l][i]} = gpDot(
						gLvl[l-1][i], pLvl[l-1][i],
						gLvl[l-1][i-span], pLvl[l-1][i-span]);
				end else begin : gPass
					assign gLvl[l][i] = gLvl[l-1][i];
					assign pLvl[l][i] = pLvl[l-1][i];
				end
			end
		end

		// fill in the middle of each block, widest first
		for (genvar d = 1; d < levels; d++) begin : gDown
			localparam int span = 2 ** (levels - d - 1);
			for (genvar i = 0; i < width; i++) begin : gBit
				if ((i + 1) % (2 * span) == span && i + 1 > 2 * span) begin : gNode
					assign {gLvl[levels+d][i], pLvl[levels+d][i]} = gpDot(
						gLvl[levels+d-1][i], pLvl[levels+d-1][i],
						gLvl[levels+d-1][i-span], pLvl[levels+d-1][i-span]);
				end else begin : gPass
					assign gLvl[levels+d][i] = gLvl[levels+d-1][i];
					assign pLvl[levels+d][i] = pLvl[levels+d-1][i];
				end
			end
		end

		assign genOut  = gLvl[2*levels-1];
		assign propOut = pLvl[2*levels-1];
	end else begin : gSklansky
		// log depth, upper half of each block taps the lower half top
		logic [levels:0][width-1:0] gLvl;
		logic [levels:0][width-1:0] pLvl;

		assign gLvl[0] = genIn;
		assign pLvl[0] = propIn;

		for (genvar l = 1; l <= levels; l++) begin : gLevel
			localparam int span = 2 ** (l - 1);
			for (genvar i = 0; i < width; i++) begin : gBit
				if (i % (2 * span) >= span) begin : gNode
					localparam int src = i - (i % span) - 1; // lower half top bit
					assign {gLvl[l][i], pLvl[l][i]} = gpDot(
						gLvl[l-1][i], pLvl[l-1][i],
						gLvl[l-1][src], pLvl[l-1][src]);
				end else begin : gPass
					assign gLvl[l][i] = gLvl[l-1][i];
					assign pLvl[l][i] = pLvl[l-1][i];
				end
			end
		end

		assign genOut  = gLvl[levels];
		assign propOut = pLvl[levels];
	end

endmodule

//--- source/prefixAdder.sv
module prefixAdder
	import addArchPkg::*;
#(
	parameter int         width = defWidth,
	parameter adderArch_e arch  = defArch
) (
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	output logic [width-1:0] sum  // mod 2**width, carry-out dropped
);

	if (arch == archRipple) begin : gRipple
		// let synthesis build the plain ripple
		assign sum = a + b;
	end else begin : gPrefix
		logic [width-1:0] bitGen;   // a and b
		logic [width-1:0] bitProp;  // xor, doubles as half sum
		logic [width-1:0] carryGen; // carry out of bit i, top one unused

		assign bitGen  = a & b;
		assign bitProp = a ^ b;

		prefixCarryNet #(
			.width(width),
			.arch (arch)
		) i_prefix (
			.genIn  (bitGen),
			.propIn (bitProp),
			.genOut (carryGen),
			.propOut()          // no carry in, group propagate not needed
		);

		// carry into bit i comes from bits below
		assign sum = bitProp ^ {carryGen[width-2:0], 1'b0};
	end

endmodule

//--- source/multiOperandAdder.sv
module multiOperandAdder
	import addArchPkg::*;
#(
	parameter int         width = defWidth,
	parameter int         depth = defDepth,
	parameter adderArch_e arch  = defArch
) (
	input  logic [depth*width-1:0] operands, // operand k at bits k*width
	output logic [width-1:0]       sum       // mod 2**width
);

	logic [width-1:0] csSum;   // carry-save sum vector
	logic [width-1:0] csCarry; // carry vector, pre-shifted

	// reduce all operands to two
	carrySaveArray #(
		.width(width),
		.depth(depth),
		.arch (arch)
	) i_csa (
		.operands(operands),
		.sum     (csSum),
		.carry   (csCarry)
	);

	// final carry-propagate add
	prefixAdder #(
		.width(width),
		.arch (arch)
	) i_cpa (
		.a  (csSum),
		.b  (csCarry),
		.sum(sum)
	);

endmodule

//--- source/mopSumUnit.sv
module mopSumUnit
	import addArchPkg::*;
	import mopIfPkg::*;
#(
	parameter adderArch_e arch = defArch
) (
	input  logic        clk,
	input  logic        rstN,
	input  operandSet_t opIn,   // new set may arrive every cycle
	output sumResult_t  sumOut  // 2 register stages behind opIn
);

	logic                 inValid;  // stage 1 strobe
	logic [defOpBits-1:0] inOps;    // stage 1 operands, flattened
	logic [defWidth-1:0]  rawSum;   // combinational datapath result
	logic                 outValid; // stage 2 strobe
	logic [defWidth-1:0]  outSum;   // stage 2 sum

	// valid pipeline, the only state that needs clearing
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			inValid  <= 1'b0;
			outValid <= 1'b0;
		end else begin
			inValid  <= opIn.valid;
			outValid <= inValid; // follows its operands through the adder
		end
	end

	// payload registers, loaded every cycle regardless of valid
	always_ff @(posedge clk) begin
		inOps  <= opIn.operands;
		outSum <= rawSum;
	end

	multiOperandAdder #(
		.width(defWidth),
		.depth(defDepth),
		.arch (arch)
	) i_adder (
		.operands(inOps),
		.sum     (rawSum)
	);

	assign sumOut.valid = outValid;
	assign sumOut.sum   = outSum;

endmodule

//--- dv/mopVectors.svh
`ifndef MOP_VECTORS_SVH
`define MOP_VECTORS_SVH

// columns: valid, operands op5 down to op0, expected sum
// rows with valid low are idle cycles, their operands and sum are don't care

typedef struct packed {
	logic                              valid;  // input strobe for this cycle
	logic [defDepth-1:0][defWidth-1:0] ops;    // op0 in the low word
	logic [defWidth-1:0]               expSum; // hand computed, mod 2**16
} vecRow_t;

localparam int numVecs = 10;

// rows go in one per cycle, no gaps unless a row says so
localparam vecRow_t vecTable [numVecs] = '{
	// all zeros
	'{1'b1, {16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}, 16'h0000},
	// all ones, 6 * ffff wraps to fffa
	'{1'b1, {16'hffff, 16'hffff, 16'hffff, 16'hffff, 16'hffff, 16'hffff}, 16'hfffa},
	// single nonzero operand in op3
	'{1'b1, {16'h0000, 16'h0000, 16'h1234, 16'h0000, 16'h0000, 16'h0000}, 16'h1234},
	// idle cycle, operands must not show up
	'{1'b0, {16'h1111, 16'h1111, 16'h1111, 16'h1111, 16'h1111, 16'h1111}, 16'h0000},
	// carry runs through all 16 bits and falls off
	'{1'b1, {16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0001, 16'hffff}, 16'h0000},
	// long chain from three small addends
	'{1'b1, {16'h0000, 16'h0000, 16'h0001, 16'h0001, 16'h0001, 16'hfffe}, 16'h0001},
	// maximum value in every operand, right after a chain
	'{1'b1, {16'hffff, 16'hffff, 16'hffff, 16'hffff, 16'hffff, 16'hffff}, 16'hfffa},
	// small distinct values, one per operand slot
	'{1'b1, {16'h0006, 16'h0005, 16'h0004, 16'h0003, 16'h0002, 16'h0001}, 16'h0015},
	// idle again
	'{1'b0, {16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}, 16'h0000},
	// top nibbles only, 0x15000 wraps to 5000
	'{1'b1, {16'h6000, 16'h5000, 16'h4000, 16'h3000, 16'h2000, 16'h1000}, 16'h5000}
};

`endif

//--- dv/tbMopSum.sv
module tbMopSum
	import addArchPkg::*;
	import mopIfPkg::*;
#(
	parameter int arch = int'(defArch) // 0 ripple, 1 Brent-Kung, 2 Sklansky
);

	`include "mopVectors.svh"

	localparam int latency   = 2;   // register stages in the DUT
	localparam int waitLimit = 20;  // cycles allowed per drain
	localparam int randSets  = 200; // back-to-back random sets

	logic        clk;
	logic        rstN;
	operandSet_t opIn;
	sumResult_t  sumOut;

	int                  cycleCount; // rising edges so far
	int                  inCount;    // valid sets driven
	int                  outCount;   // valid results seen, reset included
	logic [31:0]         lfsrState;
	logic [defWidth-1:0] expQ[$];    // expected sums, input order
	int                  edgeQ[$];   // edge count when each queued set was driven

	mopSumUnit #(
		.arch(adderArch_e'(arch))
	) i_dut (
		.clk   (clk),
		.rstN  (rstN),
		.opIn  (opIn),
		.sumOut(sumOut)
	);

	always #5 clk = ~clk; // 10 unit period

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	// every strobe leaving the DUT, also while in reset
	always @(negedge clk) begin
		if (sumOut.valid) begin
			outCount <= outCount + 1;
		end
	end

	// reference sum, carries past the top bit drop out
	function automatic logic [defWidth-1:0] modSum(
		input logic [defDepth-1:0][defWidth-1:0] ops
	);
		logic [defWidth-1:0] acc;
		acc = '0;
		for (int k = 0; k < defDepth; k++) begin
			acc = acc + ops[k];
		end
		return acc;
	endfunction

	// 32 bit fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic randWord(output logic [defWidth-1:0] w);
		w = '0;
		for (int b = 0; b < defWidth; b++) begin
			lfsrState = lfsrStep(lfsrState); // one step per bit taken
			w         = {w[defWidth-2:0], lfsrState[0]};
		end
	endtask

	task automatic failNow(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "stopping at first error");
	endtask

	// called at the falling edge, sumOut is stable there
	task automatic checkOutput();
		logic [defWidth-1:0] expSum;
		int                  expEdge;
		if (sumOut.valid) begin
			assert (expQ.size() > 0) else
				failNow("valid result appeared with no input set pending");
			expSum  = expQ.pop_front();
			expEdge = edgeQ.pop_front() + latency;
			assert (cycleCount == expEdge) else
				failNow($sformatf("FAIL sumOut.valid at edge %0h expected edge %0h",
					cycleCount, expEdge));
			assert (sumOut.sum === expSum) else
				failNow($sformatf("FAIL sumOut.sum got %h expected %h", sumOut.sum, expSum));
		end else if (edgeQ.size() > 0) begin
			// oldest set overdue means a missing strobe
			assert (cycleCount < edgeQ[0] + latency) else
				failNow($sformatf("FAIL sumOut.valid got %h expected %h", 1'b0, 1'b1));
		end
	endtask

	// one cycle: check what left, then drive the next set
	task automatic stepCycle(
		input logic                              valid,
		input logic [defDepth-1:0][defWidth-1:0] ops,
		input logic [defWidth-1:0]               expSum
	);
		@(negedge clk);
		checkOutput();
		opIn.valid    = valid;
		opIn.operands = ops;
		if (valid) begin
			expQ.push_back(expSum);
			edgeQ.push_back(cycleCount); // result due two rising edges from now
			inCount++;
		end
	endtask

	// idle until every queued set has come out
	task automatic drainPipe();
		int waited;
		waited = 0;
		while (expQ.size() > 0) begin
			assert (waited < waitLimit) else
				failNow("no result before timeout");
			stepCycle(1'b0, '0, '0);
			waited++;
		end
	endtask

	initial begin
		logic [defDepth-1:0][defWidth-1:0] ops;
		logic [defWidth-1:0]               word;
		clk        = 1'b0;
		rstN       = 1'b0;
		opIn       = '0;
		cycleCount = 0;
		inCount    = 0;
		outCount   = 0;
		lfsrState  = 32'h26d3;

		repeat (2) @(negedge clk); // reset over two rising edges
		rstN = 1'b1;

		// no strobe in, none may come out
		for (int n = 0; n < 5; n++) begin
			stepCycle(1'b0, '0, '0);
		end

		// directed rows, table sums cross-checked first
		for (int r = 0; r < numVecs; r++) begin
			if (vecTable[r].valid) begin
				assert (modSum(vecTable[r].ops) == vecTable[r].expSum) else
					failNow($sformatf("vector table row %0d holds a wrong expected sum", r));
			end
			stepCycle(vecTable[r].valid, vecTable[r].ops, vecTable[r].expSum);
		end
		drainPipe();

		// random sets, every cycle valid
		for (int n = 0; n < randSets; n++) begin
			for (int k = 0; k < defDepth; k++) begin
				randWord(word);
				ops[k] = word;
			end
			stepCycle(1'b1, ops, modSum(ops));
		end
		drainPipe();

		// trailing idle cycles catch stray strobes
		for (int n = 0; n < 5; n++) begin
			stepCycle(1'b0, '0, '0);
		end

		assert (outCount == inCount) else
			failNow($sformatf("FAIL output count got %0h expected %0h", outCount, inCount));
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- tb.f
+incdir+dv
source/addArchPkg.sv
source/mopIfPkg.sv
source/bitCompressor.sv
source/carrySaveArray.sv
source/prefixCarryNet.sv
source/prefixAdder.sv
source/multiOperandAdder.sv
source/mopSumUnit.sv
dv/tbMopSum.sv

//--- runSim.sh
#!/usr/bin/env bash
# build and run tbMopSum once per adder architecture with Verilator
# arch 0 ripple, 1 Brent-Kung, 2 Sklansky

cd "$(dirname "$0")" || exit 1

log=sim.log
: > "$log"
status=0

for arch in 0 1 2; do
	echo "=== arch $arch ===" | tee -a "$log"
	if ! verilator --binary --assert -f tb.f --top-module tbMopSum \
		-Garch=$arch --Mdir "obj_arch$arch" >> "$log" 2>&1; then
		echo "build failed for arch $arch" | tee -a "$log"
		status=1
		break
	fi
	if ! "./obj_arch$arch/VtbMopSum" >> "$log" 2>&1; then
		echo "simulation returned an error for arch $arch" | tee -a "$log"
		status=1
		break
	fi
done

if grep -q "Testbench failed" "$log"; then
	echo "failure reported, see $log"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "run aborted, see $log"
	exit 1
fi

echo "all architectures done without failure"
exit 0
